//--- design/alu_pkg.sv
package alu_pkg;

   // ----------------------------------------
   // datapath sizing
   // ----------------------------------------
   localparam int DATA_WIDTH = 16;

   // counts quotient bits during division
   localparam int CNT_WIDTH = $clog2(DATA_WIDTH);

   // ----------------------------------------
   // encodings
   // ----------------------------------------
   typedef enum logic [1:0] {
      OP_ADD = 2'd0,
      OP_SUB = 2'd1,
      OP_MUL = 2'd2,
      OP_DIV = 2'd3
   } alu_op_e;

   typedef enum logic [2:0] {
      ST_IDLE      = 3'd0,
      ST_SUB       = 3'd1,
      ST_MUL       = 3'd2,
      ST_MUL_DONE  = 3'd3,
      ST_DIV_SHIFT = 3'd4,
      ST_DIV_CMP   = 3'd5
   } alu_state_e;

endpackage

//--- design/alu_operand_if.sv
`timescale 1ns/1ps

// prepared operand facts, valid in the same cycle as the raw operands
interface alu_operand_if import alu_pkg::*; ();

   logic [DATA_WIDTH-1:0] mag_a;
   logic [DATA_WIDTH-1:0] mag_b;
   logic [DATA_WIDTH-1:0] neg_b;
   logic                  a_min;
   logic                  b_min;
   logic                  b_zero;
   logic                  res_neg;

   modport prep (
      output mag_a, mag_b, neg_b, a_min, b_min, b_zero, res_neg
   );

   modport ctrl (
      input mag_a, mag_b, neg_b, a_min, b_min, b_zero, res_neg
   );

endinterface

//--- design/alu_operand_prep.sv
`timescale 1ns/1ps

module alu_operand_prep import alu_pkg::*; (
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   alu_operand_if.prep                  o_opnd
);

   logic [DATA_WIDTH-1:0] neg_a;
   logic [DATA_WIDTH-1:0] neg_b;
   logic                  a_sign;
   logic                  b_sign;
   logic                  a_zero;
   logic                  b_zero;

   assign a_sign = i_a[DATA_WIDTH-1];
   assign b_sign = i_b[DATA_WIDTH-1];

   assign neg_a = -i_a;
   assign neg_b = -i_b;

   assign a_zero = (i_a == '0);
   assign b_zero = (i_b == '0);

   // ----------------------------------------
   // magnitudes
   // ----------------------------------------
   // the most negative value maps onto itself here, the control
   // rejects it before the magnitude is used
   assign o_opnd.mag_a = a_sign ? neg_a : i_a;
   assign o_opnd.mag_b = b_sign ? neg_b : i_b;
   assign o_opnd.neg_b = neg_b;

   // ----------------------------------------
   // range checks
   // ----------------------------------------
   // only zero and the most negative value equal their own negation
   assign o_opnd.a_min  = (i_a == neg_a) && !a_zero;
   assign o_opnd.b_min  = (i_b == neg_b) && !b_zero;
   assign o_opnd.b_zero = b_zero;

   // sign of a product or quotient of the two operands
   assign o_opnd.res_neg = a_sign ^ b_sign;

endmodule

//--- design/alu_adder.sv
`timescale 1ns/1ps

module alu_adder import alu_pkg::*; (
   input  logic [DATA_WIDTH-1:0] i_a,
   input  logic [DATA_WIDTH-1:0] i_b,
   output logic [DATA_WIDTH-1:0] o_q,
   output logic                  o_ovf
);

   logic a_sign;
   logic b_sign;
   logic q_sign;

   assign o_q = i_a + i_b;

   assign a_sign = i_a[DATA_WIDTH-1];
   assign b_sign = i_b[DATA_WIDTH-1];
   assign q_sign = o_q[DATA_WIDTH-1];

   // overflow only when both inputs agree in sign and the sum does not
   assign o_ovf = (a_sign == b_sign) && (q_sign != a_sign);

endmodule

//--- design/sequential_alu.sv
`timescale 1ns/1ps

module sequential_alu import alu_pkg::*; (
   input  logic                         i_clk,
   input  logic                         i_nrst,
   input  logic                         i_start,
   input  alu_op_e                      i_op,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,
   alu_operand_if.ctrl                  i_opnd,
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf,
   output logic                         o_zero,
   output logic                         o_done,
   output logic                         o_busy
);

   alu_state_e state;
   alu_state_e state_nxt;

   // working registers shared by all multi-cycle operations
   // op_a   multiplier bits for multiply, dividend bits for divide
   // work_a accumulator for multiply, partial remainder for divide
   // work_b multiplicand for multiply, divisor magnitude for divide
   logic [DATA_WIDTH-1:0] op_a;
   logic [DATA_WIDTH-1:0] work_a;
   logic [DATA_WIDTH-1:0] work_b;
   logic [DATA_WIDTH-1:0] quot;
   logic [CNT_WIDTH-1:0]  cnt;
   logic                  neg_r;

   logic [DATA_WIDTH-1:0] add_q;
   logic                  add_ovf;
   logic [DATA_WIDTH-1:0] work_q;
   logic                  work_ovf;
   logic [DATA_WIDTH-1:0] div_neg;
   logic [DATA_WIDTH-1:0] trial_q;
   logic [DATA_WIDTH-1:0] quot_nxt;
   logic                  quot_bit;

   logic                  fin;
   logic [DATA_WIDTH-1:0] fin_q;
   logic                  fin_ovf;

   // ----------------------------------------
   // adders
   // ----------------------------------------
   alu_adder direct_add (
      .i_a   (i_a),
      .i_b   (i_b),
      .o_q   (add_q),
      .o_ovf (add_ovf)
   );

   alu_adder work_add (
      .i_a   (work_a),
      .i_b   (work_b),
      .o_q   (work_q),
      .o_ovf (work_ovf)
   );

   // the trial subtraction of the divisor from the partial remainder
   // cannot overflow since both sides stay below 2**(DATA_WIDTH-1)
   assign div_neg = -work_b;

   alu_adder div_trial (
      .i_a   (work_a),
      .i_b   (div_neg),
      .o_q   (trial_q),
      .o_ovf ()
   );

   // a non-negative trial difference gives a one quotient bit
   assign quot_bit = ~trial_q[DATA_WIDTH-1];
   assign quot_nxt = {quot[DATA_WIDTH-2:0], quot_bit};

   // ----------------------------------------
   // next state and completion
   // ----------------------------------------
   always_comb begin
      state_nxt = state;
      fin       = 1'b0;
      fin_q     = o_q;
      fin_ovf   = 1'b0;

      case (state)
         ST_IDLE: begin
            if (i_start) begin
               case (i_op)
                  OP_ADD: begin
                     fin     = 1'b1;
                     fin_q   = add_q;
                     fin_ovf = add_ovf;
                  end
                  OP_SUB: begin
                     if (i_opnd.b_min) begin
                        fin     = 1'b1;
                        fin_ovf = 1'b1;
                     end else begin
                        state_nxt = ST_SUB;
                     end
                  end
                  OP_MUL: begin
                     if (i_opnd.a_min || i_opnd.b_min) begin
                        fin     = 1'b1;
                        fin_ovf = 1'b1;
                     end else begin
                        state_nxt = ST_MUL;
                     end
                  end
                  OP_DIV: begin
                     if (i_opnd.a_min || i_opnd.b_min || i_opnd.b_zero) begin
                        fin     = 1'b1;
                        fin_ovf = 1'b1;
                     end else begin
                        state_nxt = ST_DIV_SHIFT;
                     end
                  end
                  default: begin
                     state_nxt = ST_IDLE;
                  end
               endcase
            end
         end

         ST_SUB: begin
            fin       = 1'b1;
            fin_q     = work_q;
            fin_ovf   = work_ovf;
            state_nxt = ST_IDLE;
         end

         ST_MUL: begin
            if (op_a == '0) begin
               state_nxt = ST_MUL_DONE;
            end else if (work_ovf || work_b[DATA_WIDTH-1]) begin
               // remaining multiplier bits would push the product past the
               // signed range
               fin       = 1'b1;
               fin_ovf   = 1'b1;
               state_nxt = ST_IDLE;
            end
         end

         ST_MUL_DONE: begin
            fin       = 1'b1;
            fin_q     = neg_r ? -work_a : work_a;
            state_nxt = ST_IDLE;
         end

         ST_DIV_SHIFT: begin
            state_nxt = ST_DIV_CMP;
         end

         ST_DIV_CMP: begin
            if (cnt == CNT_WIDTH'(DATA_WIDTH - 1)) begin
               fin       = 1'b1;
               fin_q     = neg_r ? -quot_nxt : quot_nxt;
               state_nxt = ST_IDLE;
            end else begin
               state_nxt = ST_DIV_SHIFT;
            end
         end

         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   // ----------------------------------------
   // control and result registers
   // ----------------------------------------
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state  <= ST_IDLE;
         o_busy <= 1'b0;
         o_done <= 1'b0;
         o_q    <= '0;
         o_ovf  <= 1'b0;
         o_zero <= 1'b0;
      end else begin
         state  <= state_nxt;
         o_busy <= (state_nxt != ST_IDLE);
         o_done <= fin;
         if (fin) begin
            o_q    <= fin_q;
            o_ovf  <= fin_ovf;
            o_zero <= (fin_q == '0) && !fin_ovf;
         end
      end
   end

   // ----------------------------------------
   // working datapath
   // ----------------------------------------
   always_ff @(posedge i_clk) begin
      case (state)
         ST_IDLE: begin
            if (i_start) begin
               op_a  <= i_opnd.mag_a;
               cnt   <= '0;
               neg_r <= i_opnd.res_neg;
               if (i_op == OP_SUB) begin
                  work_a <= i_a;
                  work_b <= i_opnd.neg_b;
               end else begin
                  work_a <= '0;
                  work_b <= i_opnd.mag_b;
               end
            end
         end

         ST_MUL: begin
            op_a   <= op_a >> 1;
            work_b <= work_b << 1;
            if (op_a[0]) begin
               work_a <= work_q;
            end
         end

         ST_DIV_SHIFT: begin
            work_a <= {work_a[DATA_WIDTH-2:0], op_a[DATA_WIDTH-1]};
            op_a   <= op_a << 1;
         end

         ST_DIV_CMP: begin
            // restore by simply not taking a negative trial difference
            if (quot_bit) begin
               work_a <= trial_q;
            end
            quot <= quot_nxt;
            cnt  <= cnt + 1'b1;
         end
      endcase
   end

endmodule

//--- design/alu_subsystem.sv
`timescale 1ns/1ps

module alu_subsystem import alu_pkg::*; (
   input  logic                         i_clk,
   input  logic                         i_nrst,

   // operation request, sampled while o_busy is low
   input  logic                         i_start,
   input  logic [1:0]                   i_op,
   input  logic signed [DATA_WIDTH-1:0] i_a,
   input  logic signed [DATA_WIDTH-1:0] i_b,

   // result, held until the next done
   output logic signed [DATA_WIDTH-1:0] o_q,
   output logic                         o_ovf,
   output logic                         o_zero,
   output logic                         o_done,
   output logic                         o_busy
);

   // ----------------------------------------
   // operand preparation
   // ----------------------------------------
   alu_operand_if opnd_if ();

   alu_operand_prep u_operand_prep (
      .i_a    (i_a),
      .i_b    (i_b),
      .o_opnd (opnd_if.prep)
   );

   // ----------------------------------------
   // ALU control and datapath
   // ----------------------------------------
   sequential_alu u_sequential_alu (
      .i_clk   (i_clk),
      .i_nrst  (i_nrst),
      .i_start (i_start),
      .i_op    (alu_op_e'(i_op)),
      .i_a     (i_a),
      .i_b     (i_b),
      .i_opnd  (opnd_if.ctrl),
      .o_q     (o_q),
      .o_ovf   (o_ovf),
      .o_zero  (o_zero),
      .o_done  (o_done),
      .o_busy  (o_busy)
   );

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_nrst
);

   // 40 ns period
   initial begin
      o_clk = 1'b0;
      forever begin
         #20 o_clk = ~o_clk;
      end
   end

   // reset held low over the first 16 rising edges
   initial begin
      o_nrst = 1'b0;
      repeat (16) @(posedge o_clk);
      #2 o_nrst = 1'b1;
   end

endmodule

//--- tests/tb_alu_subsystem.sv
`timescale 1ns/1ps

module tb_alu_subsystem import alu_pkg::*; ();

   localparam int MAX_VAL     = (1 << (DATA_WIDTH - 1)) - 1;
   localparam int MIN_VAL     = -(1 << (DATA_WIDTH - 1));
   localparam int N_OPS       = 112;
   localparam int CYCLE_LIMIT = 40 * DATA_WIDTH * N_OPS + 200;
   // a division is the longest operation, a done later than this is lost
   localparam int DONE_WAIT   = 4 * DATA_WIDTH + 8;

   logic                         clk;
   logic                         nrst;
   logic                         start;
   logic [1:0]                   op;
   logic signed [DATA_WIDTH-1:0] a;
   logic signed [DATA_WIDTH-1:0] b;
   logic signed [DATA_WIDTH-1:0] q;
   logic                         ovf;
   logic                         zero;
   logic                         done;
   logic                         busy;

   int          value_errs = 0;
   int          proto_errs = 0;
   int          cycle_cnt  = 0;
   logic [31:0] lcg_state  = 32'h3f1a;

   tb_clock_gen u_clock_gen (
      .o_clk  (clk),
      .o_nrst (nrst)
   );

   alu_subsystem dut (
      .i_clk   (clk),
      .i_nrst  (nrst),
      .i_start (start),
      .i_op    (op),
      .i_a     (a),
      .i_b     (b),
      .o_q     (q),
      .o_ovf   (ovf),
      .o_zero  (zero),
      .o_done  (done),
      .o_busy  (busy)
   );

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // signed value of the given width taken from the upper generator bits
   function automatic int rand_word(input int bits);
      lcg_state = lcg_step(lcg_state);
      return int'(lcg_state[31:8] % (1 << bits)) - (1 << (bits - 1));
   endfunction

   // ----------------------------------------
   // reference model
   // ----------------------------------------
   // edge -1 means the latency is not fixed
   task automatic predict_result(input alu_op_e op_in, input int a_in, input int b_in,
                                 output int exp_q, output bit exp_ovf, output int exp_edge);
      int mag;
      exp_q    = 0;
      exp_ovf  = 1'b0;
      exp_edge = 0;
      case (op_in)
         OP_ADD: exp_q = a_in + b_in;
         OP_SUB: begin
            if (b_in == MIN_VAL) begin
               exp_ovf = 1'b1;
            end else begin
               exp_q    = a_in - b_in;
               exp_edge = 1;
            end
         end
         OP_MUL: begin
            if (a_in == MIN_VAL || b_in == MIN_VAL) begin
               exp_ovf = 1'b1;
            end else begin
               exp_q    = a_in * b_in;
               mag      = (exp_q < 0) ? -exp_q : exp_q;
               exp_ovf  = (mag > MAX_VAL);
               exp_edge = -1;
            end
         end
         default: begin
            if (b_in == 0 || a_in == MIN_VAL || b_in == MIN_VAL) begin
               exp_ovf = 1'b1;
            end else begin
               // integer division already truncates toward zero
               exp_q    = a_in / b_in;
               exp_edge = 2 * DATA_WIDTH;
            end
         end
      endcase
      if (op_in == OP_ADD || op_in == OP_SUB) begin
         exp_ovf = exp_ovf || exp_q > MAX_VAL || exp_q < MIN_VAL;
      end
   endtask

   task automatic check_outputs(input alu_op_e op_in, input int a_in, input int b_in,
                                input int exp_q, input bit exp_ovf);
      int got_q;
      bit exp_zero;
      got_q    = q;
      exp_zero = (exp_q == 0) && !exp_ovf;
      if (ovf !== exp_ovf) begin
         value_errs++;
         $display("ERR %0t: op %0d a=%0d b=%0d ovf %b, expected %b",
                  $time, op_in, a_in, b_in, ovf, exp_ovf);
      end
      if (!exp_ovf && got_q != exp_q) begin
         value_errs++;
         $display("ERR %0t: op %0d a=%0d b=%0d q %0d, expected %0d",
                  $time, op_in, a_in, b_in, got_q, exp_q);
      end
      if (zero !== exp_zero) begin
         value_errs++;
         $display("ERR %0t: op %0d a=%0d b=%0d zero %b, expected %b",
                  $time, op_in, a_in, b_in, zero, exp_zero);
      end
      if (busy !== 1'b0) begin
         value_errs++;
         $display("ERR %0t: op %0d busy still high at done", $time, op_in);
      end
   endtask

   task automatic run_op(input alu_op_e op_in, input int a_in, input int b_in);
      int exp_q;
      bit exp_ovf;
      int exp_edge;
      int edge_n;
      predict_result(op_in, a_in, b_in, exp_q, exp_ovf, exp_edge);
      @(posedge clk);
      #2;
      start = 1'b1;
      op    = op_in;
      a     = DATA_WIDTH'(a_in);
      b     = DATA_WIDTH'(b_in);
      @(posedge clk);
      #2;
      start  = 1'b0;
      edge_n = 0;
      while (done !== 1'b1 && edge_n < DONE_WAIT) begin
         if (busy !== 1'b1) begin
            value_errs++;
            $display("ERR %0t: op %0d busy low before done", $time, op_in);
         end
         @(posedge clk);
         #2;
         edge_n++;
      end
      if (done !== 1'b1) begin
         proto_errs++;
         $display("op %0d with a=%0d b=%0d never signalled done", op_in, a_in, b_in);
      end else begin
         if (exp_edge >= 0 && edge_n != exp_edge) begin
            value_errs++;
            $display("ERR %0t: op %0d done at edge %0d, expected edge %0d",
                     $time, op_in, edge_n, exp_edge);
         end
         check_outputs(op_in, a_in, b_in, exp_q, exp_ovf);
      end
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------
   task automatic check_reset();
      @(posedge nrst);
      #1;
      if (done !== 1'b0 || busy !== 1'b0 || ovf !== 1'b0 || zero !== 1'b0 || q !== '0) begin
         value_errs++;
         $display("ERR %0t: outputs not cleared by reset", $time);
      end
   endtask

   task automatic test_add_sub();
      int corner [5] = '{0, 1, -1, MAX_VAL, MIN_VAL};
      foreach (corner[i]) begin
         foreach (corner[j]) begin
            run_op(OP_ADD, corner[i], corner[j]);
            run_op(OP_SUB, corner[i], corner[j]);
         end
      end
      repeat (8) begin
         run_op(OP_ADD, rand_word(16), rand_word(16));
         run_op(OP_SUB, rand_word(16), rand_word(16));
      end
   endtask

   task automatic test_mul();
      int ma;
      int mb;
      repeat (4) begin
         ma = rand_word(8) & 127;
         mb = rand_word(8) & 127;
         run_op(OP_MUL, ma, mb);
         run_op(OP_MUL, -ma, mb);
         run_op(OP_MUL, ma, -mb);
         run_op(OP_MUL, -ma, -mb);
      end
      // products around 2**15, the third one lands exactly on the most negative value
      run_op(OP_MUL, 181, 181);
      run_op(OP_MUL, -255, -128);
      run_op(OP_MUL, -128, 256);
      run_op(OP_MUL, 128, 256);
      run_op(OP_MUL, 200, 200);
      run_op(OP_MUL, MAX_VAL, -1);
      run_op(OP_MUL, MIN_VAL, 1);
      run_op(OP_MUL, 3, MIN_VAL);
   endtask

   task automatic test_div();
      for (int s = 0; s < 4; s++) begin
         run_op(OP_DIV, s[0] ? -100 : 100, s[1] ? -7 : 7);
         run_op(OP_DIV, s[0] ? -MAX_VAL : MAX_VAL, s[1] ? -3 : 3);
      end
      repeat (4) begin
         run_op(OP_DIV, rand_word(16), rand_word(8));
      end
      run_op(OP_DIV, 7, 0);
      run_op(OP_DIV, MIN_VAL, 3);
      run_op(OP_DIV, 3, MIN_VAL);
   endtask

   task automatic test_zero_flag();
      run_op(OP_SUB, 1234, 1234);
      run_op(OP_MUL, 0, -77);
      run_op(OP_DIV, 3, 1000);
      // wraps to zero with overflow, so zero must stay low
      run_op(OP_ADD, MIN_VAL, MIN_VAL);
   endtask

   // a second start in the middle of a division has to be dropped
   task automatic test_busy();
      int exp_q;
      bit exp_ovf;
      int exp_edge;
      int dones;
      predict_result(OP_DIV, 30000, -7, exp_q, exp_ovf, exp_edge);
      @(posedge clk);
      #2;
      start = 1'b1;
      op    = OP_DIV;
      a     = DATA_WIDTH'(30000);
      b     = DATA_WIDTH'(-7);
      @(posedge clk);
      #2;
      start = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      start = 1'b1;
      op    = OP_ADD;
      a     = DATA_WIDTH'(1);
      b     = DATA_WIDTH'(2);
      @(posedge clk);
      #2;
      start = 1'b0;
      dones = 0;
      repeat (3 * DATA_WIDTH) begin
         if (done === 1'b1) begin
            dones++;
            check_outputs(OP_DIV, 30000, -7, exp_q, exp_ovf);
         end
         @(posedge clk);
         #2;
      end
      if (dones != 1) begin
         value_errs++;
         $display("ERR %0t: %0d done pulses around an ignored start, expected 1",
                  $time, dones);
      end
   endtask

   // ----------------------------------------
   // run control
   // ----------------------------------------
   initial begin
      start = 1'b0;
      op    = OP_ADD;
      a     = '0;
      b     = '0;
      check_reset();
      test_add_sub();
      test_mul();
      test_div();
      test_zero_flag();
      test_busy();
      $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
      if (value_errs == 0 && proto_errs == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycle_cnt++;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("timeout: run stopped after %0d cycles", cycle_cnt);
         $display("errors: value %0d, protocol %0d", value_errs, proto_errs);
         $display("TEST FAIL");
         $finish;
      end
   end

endmodule

//--- alu_subsystem.f
design/alu_pkg.sv
design/alu_operand_if.sv
design/alu_operand_prep.sv
design/alu_adder.sv
design/sequential_alu.sv
design/alu_subsystem.sv
tests/tb_clock_gen.sv
tests/tb_alu_subsystem.sv
